/* Bender.yml */
package:
  name: cpu

sources:
  - files:
      - design/cpu_pkg.sv
      - design/mem_port_if.sv
      - design/sram.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/forwarding_unit.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/cpu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpu_tb.sv

/* design/cpu.sv */
`timescale 1ns/10ps

module cpu (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           enable,
   // instruction memory access
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  logic           ren_ext,
   input  cpu_pkg::word_t wdata_ext,
   output cpu_pkg::word_t rdata_ext,
   // data memory access
   input  cpu_pkg::word_t addr_ext_2,
   input  logic           wen_ext_2,
   input  logic           ren_ext_2,
   input  cpu_pkg::word_t wdata_ext_2,
   output cpu_pkg::word_t rdata_ext_2
);
   import cpu_pkg::*;

   word_t   instr;
   word_t   pc_plus4;
   logic    stall;
   logic    redirect;
   word_t   target;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_bus_t wb;

   mem_port_if imem_ext_if ();
   mem_port_if dmem_ext_if ();

   assign imem_ext_if.addr  = addr_ext;
   assign imem_ext_if.wen   = wen_ext;
   assign imem_ext_if.ren   = ren_ext;
   assign imem_ext_if.wdata = wdata_ext;
   assign rdata_ext         = imem_ext_if.rdata;

   assign dmem_ext_if.addr  = addr_ext_2;
   assign dmem_ext_if.wen   = wen_ext_2;
   assign dmem_ext_if.ren   = ren_ext_2;
   assign dmem_ext_if.wdata = wdata_ext_2;
   assign rdata_ext_2       = dmem_ext_if.rdata;

   fetch_stage fetch_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .stall   (stall),
      .redirect(redirect),
      .target  (target),
      .imem_ext(imem_ext_if),
      .instr   (instr),
      .pc_plus4(pc_plus4)
   );

   decode_stage decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .instr   (instr),
      .pc_plus4(pc_plus4),
      .wb      (wb),
      .stall   (stall),
      .redirect(redirect),
      .target  (target),
      .id_ex   (id_ex)
   );

   execute_stage execute_i (
      .clk   (clk),
      .rst_n (rst_n),
      .enable(enable),
      .id_ex (id_ex),
      .wb    (wb),
      .ex_mem(ex_mem)
   );

   memory_stage memory_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .enable  (enable),
      .ex_mem  (ex_mem),
      .dmem_ext(dmem_ext_if),
      .wb      (wb)
   );

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

   localparam int data_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   typedef logic [data_w-1:0]     word_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;

   // primary opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_j     = 6'h02;
   localparam logic [5:0] op_beq   = 6'h04;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_sw    = 6'h2b;

   // r-type function field
   localparam logic [5:0] funct_add = 6'h20;
   localparam logic [5:0] funct_sub = 6'h22;
   localparam logic [5:0] funct_and = 6'h24;
   localparam logic [5:0] funct_or  = 6'h25;
   localparam logic [5:0] funct_slt = 6'h2a;

   // operand source select from the forwarding unit
   localparam logic [1:0] fwd_reg    = 2'b00;
   localparam logic [1:0] fwd_wb     = 2'b01;
   localparam logic [1:0] fwd_ex_mem = 2'b10;

   typedef enum logic [2:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_slt = 3'd4
   } alu_op_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    alu_src;
      alu_op_e alu_op;
   } ctrl_t;

   typedef struct packed {
      ctrl_t     ctrl;
      word_t     rs_val;
      word_t     rt_val;
      word_t     imm;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t dest;
   } id_ex_t;

   typedef struct packed {
      ctrl_t     ctrl;
      word_t     alu_result;
      word_t     store_data;
      reg_addr_t dest;
   } ex_mem_t;

   typedef struct packed {
      logic      reg_write;
      reg_addr_t waddr;
      word_t     wdata;
   } wb_bus_t;

endpackage

/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              enable,
   input  cpu_pkg::word_t    instr,
   input  cpu_pkg::word_t    pc_plus4,
   input  cpu_pkg::wb_bus_t  wb,
   output logic              stall,
   output logic              redirect,
   output cpu_pkg::word_t    target,
   output cpu_pkg::id_ex_t   id_ex
);
   import cpu_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   word_t      imm;
   word_t      rs_val;
   word_t      rt_val;
   ctrl_t      ctrl;
   logic       is_beq;
   logic       is_j;
   logic       uses_rs;
   logic       uses_rt;
   id_ex_t     id_ex_d;
   word_t      regs [32];

   assign opcode = instr[31:26];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign funct  = instr[5:0];
   assign imm    = {{16{instr[15]}}, instr[15:0]};

   assign is_beq  = (opcode == op_beq);
   assign is_j    = (opcode == op_j);
   assign uses_rs = !is_j;
   assign uses_rt = (opcode == op_rtype) || (opcode == op_sw) || is_beq;

   always_comb begin
      ctrl = '0;
      unique case (opcode)
         op_rtype: begin
            ctrl.reg_write = 1'b1;
            unique case (funct)
               funct_add: ctrl.alu_op = alu_add;
               funct_sub: ctrl.alu_op = alu_sub;
               funct_and: ctrl.alu_op = alu_and;
               funct_or:  ctrl.alu_op = alu_or;
               funct_slt: ctrl.alu_op = alu_slt;
               // unknown funct (also the flushed zero word)
               default:   ctrl = '0;
            endcase
         end
         op_addi: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         op_lw: begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.alu_src    = 1'b1;
         end
         op_sw: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

   // register file, same-cycle writeback passes through
   function automatic word_t read_reg(reg_addr_t a, wb_bus_t w, word_t q);
      if (a == '0) begin
         return '0;
      end
      if (w.reg_write && w.waddr == a) begin
         return w.wdata;
      end
      return q;
   endfunction

   assign rs_val = read_reg(rs, wb, regs[rs]);
   assign rt_val = read_reg(rt, wb, regs[rt]);

   always_ff @(posedge clk) begin
      if (enable && wb.reg_write && wb.waddr != '0) begin
         regs[wb.waddr] <= wb.wdata;
      end
   end

   // load in ID/EX feeding this instruction
   assign stall = id_ex.ctrl.mem_read && id_ex.dest != '0 &&
                  ((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

   assign redirect = !stall && (is_j || (is_beq && rs_val == rt_val));
   assign target   = is_j ? {pc_plus4[31:28], instr[25:0], 2'b00}
                          : pc_plus4 + {imm[29:0], 2'b00};

   always_comb begin
      id_ex_d.ctrl   = stall ? '0 : ctrl;
      id_ex_d.rs_val = rs_val;
      id_ex_d.rt_val = rt_val;
      id_ex_d.imm    = imm;
      id_ex_d.rs     = rs;
      id_ex_d.rt     = rt;
      id_ex_d.dest   = (opcode == op_rtype) ? rd : rt;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= '0;
      end else if (enable) begin
         id_ex <= id_ex_d;
      end
   end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              enable,
   input  cpu_pkg::id_ex_t   id_ex,
   input  cpu_pkg::wb_bus_t  wb,
   output cpu_pkg::ex_mem_t  ex_mem
);
   import cpu_pkg::*;

   logic [1:0] fwd_a;
   logic [1:0] fwd_b;
   word_t      op_a;
   word_t      rt_fwd;
   word_t      op_b;
   word_t      result;

   forwarding_unit forwarding_unit_i (
      .rs    (id_ex.rs),
      .rt    (id_ex.rt),
      .ex_mem(ex_mem),
      .wb    (wb),
      .fwd_a (fwd_a),
      .fwd_b (fwd_b)
   );

   function automatic word_t pick(logic [1:0] sel, word_t reg_val, word_t em_val,
                                  word_t wb_val);
      unique case (sel)
         fwd_ex_mem: return em_val;
         fwd_wb:     return wb_val;
         default:    return reg_val;
      endcase
   endfunction

   assign op_a   = pick(fwd_a, id_ex.rs_val, ex_mem.alu_result, wb.wdata);
   assign rt_fwd = pick(fwd_b, id_ex.rt_val, ex_mem.alu_result, wb.wdata);
   assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_fwd;

   always_comb begin
      unique case (id_ex.ctrl.alu_op)
         alu_add: result = op_a + op_b;
         alu_sub: result = op_a - op_b;
         alu_and: result = op_a & op_b;
         alu_or:  result = op_a | op_b;
         alu_slt: result = word_t'($signed(op_a) < $signed(op_b));
         default: result = '0;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.alu_result <= result;
         ex_mem.store_data <= rt_fwd;
         ex_mem.dest       <= id_ex.dest;
      end
   end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           enable,
   input  logic           stall,
   input  logic           redirect,
   input  cpu_pkg::word_t target,
   mem_port_if.mem        imem_ext,
   output cpu_pkg::word_t instr,
   output cpu_pkg::word_t pc_plus4
);
   import cpu_pkg::*;

   word_t pc;
   word_t pc_seq;

   mem_port_if imem_core ();

   assign pc_seq = pc + 32'd4;

   // instruction fetch only reads
   assign imem_core.addr  = pc;
   assign imem_core.wen   = 1'b0;
   assign imem_core.ren   = 1'b1;
   assign imem_core.wdata = '0;

   sram #(
      .addr_w(imem_addr_w)
   ) imem_i (
      .clk (clk),
      .core(imem_core),
      .ext (imem_ext)
   );

   // not-taken assumed, decode redirects
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (enable && !stall) begin
         pc <= redirect ? target : pc_seq;
      end
   end

   // IF/ID register, a zero word decodes as a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr    <= '0;
         pc_plus4 <= '0;
      end else if (enable && !stall) begin
         instr    <= redirect ? '0 : imem_core.rdata;
         pc_plus4 <= pc_seq;
      end
   end

endmodule

/* design/forwarding_unit.sv */
`timescale 1ns/10ps

module forwarding_unit (
   input  cpu_pkg::reg_addr_t rs,
   input  cpu_pkg::reg_addr_t rt,
   input  cpu_pkg::ex_mem_t   ex_mem,
   input  cpu_pkg::wb_bus_t   wb,
   output logic [1:0]         fwd_a,
   output logic [1:0]         fwd_b
);
   import cpu_pkg::*;

   // newest producer first, a load in EX/MEM has no data yet
   function automatic logic [1:0] select_src(reg_addr_t src, ex_mem_t em, wb_bus_t w);
      if (src == '0) begin
         return fwd_reg;
      end
      if (em.ctrl.reg_write && !em.ctrl.mem_read && em.dest == src) begin
         return fwd_ex_mem;
      end
      if (w.reg_write && w.waddr == src) begin
         return fwd_wb;
      end
      return fwd_reg;
   endfunction

   always_comb begin
      fwd_a = select_src(rs, ex_mem, wb);
      fwd_b = select_src(rt, ex_mem, wb);
   end

endmodule

/* design/mem_port_if.sv */
`timescale 1ns/10ps

interface mem_port_if;
   import cpu_pkg::*;

   // byte address, the memory uses the word index
   word_t addr;
   logic  wen;
   logic  ren;
   word_t wdata;
   word_t rdata;

   modport host (
      output addr,
      output wen,
      output ren,
      output wdata,
      input  rdata
   );

   modport mem (
      input  addr,
      input  wen,
      input  ren,
      input  wdata,
      output rdata
   );

endinterface

/* design/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              enable,
   input  cpu_pkg::ex_mem_t  ex_mem,
   mem_port_if.mem           dmem_ext,
   output cpu_pkg::wb_bus_t  wb
);
   import cpu_pkg::*;

   logic      mw_reg_write;
   logic      mw_mem_to_reg;
   reg_addr_t mw_dest;
   word_t     mw_load;
   word_t     mw_alu;

   mem_port_if dmem_core ();

   // no store while the pipeline is frozen
   assign dmem_core.addr  = ex_mem.alu_result;
   assign dmem_core.wen   = ex_mem.ctrl.mem_write && enable;
   assign dmem_core.ren   = ex_mem.ctrl.mem_read;
   assign dmem_core.wdata = ex_mem.store_data;

   sram #(
      .addr_w(dmem_addr_w)
   ) dmem_i (
      .clk (clk),
      .core(dmem_core),
      .ext (dmem_ext)
   );

   // MEM/WB register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mw_reg_write  <= 1'b0;
         mw_mem_to_reg <= 1'b0;
         mw_dest       <= '0;
      end else if (enable) begin
         mw_reg_write  <= ex_mem.ctrl.reg_write;
         mw_mem_to_reg <= ex_mem.ctrl.mem_to_reg;
         mw_dest       <= ex_mem.dest;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mw_load <= dmem_core.rdata;
         mw_alu  <= ex_mem.alu_result;
      end
   end

   always_comb begin
      wb.reg_write = mw_reg_write;
      wb.waddr     = mw_dest;
      wb.wdata     = mw_mem_to_reg ? mw_load : mw_alu;
   end

endmodule

/* design/sram.sv */
`timescale 1ns/10ps

module sram #(
   parameter int addr_w = 9
) (
   input  logic   clk,
   mem_port_if.mem core,
   mem_port_if.mem ext
);
   import cpu_pkg::*;

   word_t             mem [2**addr_w];
   logic [addr_w-1:0] core_idx;
   logic [addr_w-1:0] ext_idx;

   assign core_idx = core.addr[addr_w+1:2];
   assign ext_idx  = ext.addr[addr_w+1:2];

   // core side reads in the same cycle
   assign core.rdata = core.ren ? mem[core_idx] : '0;

   // external write comes last so it wins on a clash
   always_ff @(posedge clk) begin
      if (core.wen) begin
         mem[core_idx] <= core.wdata;
      end
      if (ext.wen) begin
         mem[ext_idx] <= ext.wdata;
      end
   end

   // registered external read, held until the next read
   always_ff @(posedge clk) begin
      if (ext.ren) begin
         ext.rdata <= mem[ext_idx];
      end
   end

endmodule

/* filelist.f */
+incdir+verification
design/cpu_pkg.sv
design/mem_port_if.sv
design/sram.sv
design/fetch_stage.sv
design/decode_stage.sv
design/forwarding_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu.sv
verification/cpu_tb.sv

/* verification/cpu_tb_programs.svh */
// lfsr state shared by every random draw in the testbench
word_t lfsr_state = 32'h8438_9680;
word_t prog [$];
word_t data_img [64];

// fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
function automatic word_t take_bits(input int n);
   word_t bits;
   logic  fb;
   bits = '0;
   repeat (n) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
   end
   return bits;
endfunction

function automatic word_t enc_r(input logic [5:0] funct, input reg_addr_t rd,
                                input reg_addr_t rs, input reg_addr_t rt);
   return {op_rtype, rs, rt, rd, 5'd0, funct};
endfunction

// operands in the order of the assembly form addi rt, rs, imm
function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
                                input reg_addr_t rs, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(input int word_idx);
   return {op_j, 26'(word_idx)};
endfunction

function automatic word_t fill_pattern(input word_t addr);
   return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0000;
endfunction

task automatic emit(input word_t w);
   prog.push_back(w);
endtask

// jump to self marks the end of a program
task automatic finish_prog();
   emit(enc_j(prog.size()));
endtask

task automatic fill_data();
   int i;
   for (i = 0; i < 64; i++) begin
      data_img[i] = fill_pattern(word_t'(i * 4));
   end
   for (i = 0; i < 8; i++) begin
      data_img[i] = take_bits(32);
   end
endtask

task automatic build_alu_prog();
   int r;
   prog.delete();
   emit(enc_i(op_lw, 1, 0, 16'd0));
   emit(enc_i(op_lw, 2, 0, 16'd4));
   emit(enc_i(op_lw, 3, 0, 16'd8));
   emit(enc_i(op_addi, 4, 0, 16'(take_bits(16))));
   emit(enc_i(op_addi, 5, 0, 16'(take_bits(16))));
   emit(enc_r(funct_add, 6, 1, 2));
   emit(enc_r(funct_sub, 7, 1, 3));
   emit(enc_r(funct_and, 8, 2, 3));
   emit(enc_r(funct_or, 9, 3, 4));
   emit(enc_r(funct_slt, 10, 1, 2));
   emit(enc_r(funct_slt, 11, 5, 4));
   emit(enc_i(op_addi, 12, 3, 16'(take_bits(16))));
   for (r = 6; r <= 12; r++) begin
      emit(enc_i(op_sw, reg_addr_t'(r), 0, 16'(128 + 4 * r)));
   end
   finish_prog();
endtask

task automatic build_fwd_prog();
   int r;
   prog.delete();
   emit(enc_i(op_lw, 1, 0, 16'd0));
   emit(enc_i(op_lw, 2, 0, 16'd4));
   emit(enc_i(op_addi, 20, 0, 16'(take_bits(16))));
   emit(enc_i(op_addi, 21, 0, 16'(take_bits(16))));
   // each result feeds the next one or two instructions
   emit(enc_r(funct_add, 3, 1, 2));
   emit(enc_r(funct_sub, 4, 3, 1));
   emit(enc_r(funct_or, 5, 4, 3));
   emit(enc_r(funct_and, 6, 5, 4));
   emit(enc_r(funct_slt, 7, 6, 5));
   emit(enc_r(funct_add, 8, 7, 6));
   emit(enc_i(op_addi, 9, 8, 16'(take_bits(16))));
   emit(enc_i(op_sw, 9, 0, 16'd164));
   for (r = 3; r <= 8; r++) begin
      emit(enc_i(op_sw, reg_addr_t'(r), 0, 16'(128 + 4 * r)));
   end
   finish_prog();
endtask

task automatic build_load_use_prog();
   prog.delete();
   emit(enc_i(op_lw, 1, 0, 16'd0));
   emit(enc_i(op_lw, 2, 0, 16'd4));
   emit(enc_i(op_addi, 20, 0, 16'(take_bits(16))));
   emit(enc_i(op_addi, 21, 0, 16'(take_bits(16))));
   emit(enc_i(op_lw, 3, 0, 16'd8));
   emit(enc_r(funct_add, 4, 3, 1));
   emit(enc_i(op_lw, 5, 0, 16'd12));
   emit(enc_i(op_sw, 5, 0, 16'd132));
   emit(enc_i(op_lw, 6, 0, 16'd16));
   emit(enc_r(funct_sub, 7, 2, 6));
   emit(enc_i(op_lw, 8, 0, 16'd20));
   emit(enc_r(funct_add, 9, 8, 8));
   emit(enc_i(op_sw, 4, 0, 16'd128));
   emit(enc_i(op_sw, 7, 0, 16'd136));
   emit(enc_i(op_sw, 9, 0, 16'd140));
   finish_prog();
endtask

task automatic build_branch_prog();
   prog.delete();
   emit(enc_i(op_addi, 1, 0, 16'd5));
   emit(enc_i(op_addi, 2, 0, 16'd5));
   emit(enc_i(op_addi, 3, 0, 16'd7));
   emit(enc_i(op_addi, 9, 0, 16'(take_bits(16))));
   // taken beq skips the next store
   emit(enc_i(op_beq, 2, 1, 16'd1));
   emit(enc_i(op_sw, 9, 0, 16'd128));
   emit(enc_i(op_sw, 9, 0, 16'd132));
   // not taken
   emit(enc_i(op_beq, 3, 1, 16'd1));
   emit(enc_i(op_sw, 9, 0, 16'd136));
   emit(enc_j(11));
   emit(enc_i(op_sw, 9, 0, 16'd140));
   emit(enc_i(op_sw, 9, 0, 16'd144));
   finish_prog();
endtask

/* verification/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;
   import cpu_pkg::*;

   logic  clk;
   logic  rst_n;
   logic  enable;
   word_t addr_ext;
   logic  wen_ext;
   logic  ren_ext;
   word_t wdata_ext;
   word_t rdata_ext;
   word_t addr_ext_2;
   logic  wen_ext_2;
   logic  ren_ext_2;
   word_t wdata_ext_2;
   word_t rdata_ext_2;

   int    errors        = 0;
   int    checks        = 0;
   int    tests_run     = 0;
   int    budget_cycles = 400;
   int    cycle_count   = 0;
   word_t model_mem [64];

   `include "cpu_tb_programs.svh"

   cpu cpu_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (enable),
      .addr_ext   (addr_ext),
      .wen_ext    (wen_ext),
      .ren_ext    (ren_ext),
      .wdata_ext  (wdata_ext),
      .rdata_ext  (rdata_ext),
      .addr_ext_2 (addr_ext_2),
      .wen_ext_2  (wen_ext_2),
      .ren_ext_2  (ren_ext_2),
      .wdata_ext_2(wdata_ext_2),
      .rdata_ext_2(rdata_ext_2)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // budget grows as each test starts
   initial begin
      while (cycle_count <= budget_cycles + 100) begin
         @(posedge clk);
      end
      $display("watchdog: run went past %0d cycles without finishing", cycle_count);
      $display("FAIL: see errors above");
      $finish;
   end

   task automatic reset_dut();
      @(negedge clk);
      rst_n  = 1'b0;
      enable = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic ext_write(input logic dmem, input word_t addr, input word_t data);
      @(negedge clk);
      if (dmem) begin
         addr_ext_2  = addr;
         wdata_ext_2 = data;
         wen_ext_2   = 1'b1;
      end else begin
         addr_ext  = addr;
         wdata_ext = data;
         wen_ext   = 1'b1;
      end
      @(negedge clk);
      wen_ext   = 1'b0;
      wen_ext_2 = 1'b0;
   endtask

   // rdata is registered, so sample one cycle after ren
   task automatic ext_read(input logic dmem, input word_t addr, output word_t data);
      @(negedge clk);
      if (dmem) begin
         addr_ext_2 = addr;
         ren_ext_2  = 1'b1;
      end else begin
         addr_ext = addr;
         ren_ext  = 1'b1;
      end
      @(negedge clk);
      ren_ext   = 1'b0;
      ren_ext_2 = 1'b0;
      data      = dmem ? rdata_ext_2 : rdata_ext;
   endtask

   task automatic check_word(input string what, input word_t exp, input word_t act);
      checks++;
      assert (act === exp) else begin
         $display("[ERROR] %s: expected %h actual %h", what, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int chk0, input int err0);
      tests_run++;
      $display("test %-10s %0d checks, %0d errors", name, checks - chk0, errors - err0);
   endtask

   // instruction-level reference, one instruction per step
   task automatic run_model();
      word_t      regs [32];
      word_t      ir;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      val;
      word_t      ea;
      logic [5:0] op;
      reg_addr_t  dst;
      logic       wr;
      logic       done;
      int         pc;
      int         steps;
      foreach (regs[r]) begin
         regs[r] = '0;
      end
      model_mem = data_img;
      pc    = 0;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 1000 && pc < prog.size()) begin
         ir    = prog[pc];
         op    = ir[31:26];
         a     = regs[ir[25:21]];
         b     = regs[ir[20:16]];
         imm   = {{16{ir[15]}}, ir[15:0]};
         ea    = a + imm;
         dst   = ir[20:16];
         wr    = 1'b1;
         val   = '0;
         steps = steps + 1;
         if (op == op_j) begin
            done = (ir[25:0] == pc);
            pc   = ir[25:0];
         end else if (op == op_beq) begin
            pc = (a == b) ? pc + 1 + int'($signed(imm)) : pc + 1;
         end else begin
            case (op)
               op_rtype: begin
                  dst = ir[15:11];
                  case (ir[5:0])
                     funct_add: val = a + b;
                     funct_sub: val = a - b;
                     funct_and: val = a & b;
                     funct_or:  val = a | b;
                     funct_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                     default:   wr = 1'b0;
                  endcase
               end
               op_addi: val = ea;
               op_lw:   val = model_mem[ea[7:2]];
               op_sw: begin
                  model_mem[ea[7:2]] = b;
                  wr = 1'b0;
               end
               default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
               regs[dst] = val;
            end
            pc = pc + 1;
         end
      end
   endtask

   task automatic test_ext_access();
      word_t exp_i [16];
      word_t exp_d [16];
      word_t got;
      int    i;
      int    chk0;
      int    err0;
      chk0 = checks;
      err0 = errors;
      for (i = 0; i < 16; i++) begin
         exp_i[i] = take_bits(32);
         exp_d[i] = take_bits(32);
         ext_write(1'b0, word_t'((i * 37 % 512) * 4), exp_i[i]);
         ext_write(1'b1, word_t'((i * 61 % 1024) * 4), exp_d[i]);
      end
      for (i = 0; i < 16; i++) begin
         ext_read(1'b0, word_t'((i * 37 % 512) * 4), got);
         check_word($sformatf("ext_access imem word %0d", i * 37 % 512), exp_i[i], got);
         ext_read(1'b1, word_t'((i * 61 % 1024) * 4), got);
         check_word($sformatf("ext_access dmem word %0d", i * 61 % 1024), exp_d[i], got);
      end
      report_test("ext_access", chk0, err0);
   endtask

   task automatic run_program(input string name);
      word_t final_pc;
      word_t got;
      int    bound;
      int    cycles;
      int    i;
      int    chk0;
      int    err0;
      chk0  = checks;
      err0  = errors;
      bound = prog.size() * 4 + 20;
      budget_cycles += bound + prog.size() * 2 + 64 * 4 + 30;
      reset_dut();
      foreach (prog[k]) begin
         ext_write(1'b0, word_t'(k * 4), prog[k]);
      end
      for (i = 0; i < 64; i++) begin
         ext_write(1'b1, word_t'(i * 4), data_img[i]);
      end
      run_model();
      final_pc = word_t'((prog.size() - 1) * 4);
      @(negedge clk);
      enable = 1'b1;
      cycles = 0;
      while (cpu_i.fetch_i.pc !== final_pc && cycles < bound) begin
         @(negedge clk);
         cycles++;
      end
      if (cpu_i.fetch_i.pc !== final_pc) begin
         $display("%s: the pc did not reach the final jump within %0d cycles", name, bound);
         errors++;
      end
      // let the instructions ahead of the final jump retire
      repeat (6) @(negedge clk);
      enable = 1'b0;
      for (i = 0; i < 64; i++) begin
         ext_read(1'b1, word_t'(i * 4), got);
         check_word($sformatf("%s dmem word %0d", name, i), model_mem[i], got);
      end
      report_test(name, chk0, err0);
   endtask

   initial begin
      rst_n       = 1'b0;
      enable      = 1'b0;
      addr_ext    = '0;
      wen_ext     = 1'b0;
      ren_ext     = 1'b0;
      wdata_ext   = '0;
      addr_ext_2  = '0;
      wen_ext_2   = 1'b0;
      ren_ext_2   = 1'b0;
      wdata_ext_2 = '0;
      reset_dut();
      test_ext_access();
      fill_data();
      build_alu_prog();
      run_program("alu");
      fill_data();
      build_fwd_prog();
      run_program("forward");
      fill_data();
      build_load_use_prog();
      run_program("load_use");
      fill_data();
      build_branch_prog();
      run_program("branch");
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
